/* common/memoryGame_defs.svh */
/*
 * Memory game constants
 * Sequence depth, round limits, press windows and LED timing
 */

`ifndef MEMORY_GAME_DEFS_SVH
`define MEMORY_GAME_DEFS_SVH

// Entries in the sequence ROM
`define SEQ_DEPTH 16

// Last round index for each round level
`define EASY_LAST 3
`define HARD_LAST 15

// Cycles allowed for each press
`define PLAY_TIMEOUT_LONG  128
`define PLAY_TIMEOUT_SHORT 64

// Show phase timing in cycles
`define LED_ON_CYCLES  8
`define LED_OFF_CYCLES 4

`endif

/* common/memoryGamePkg.sv */
/*
 * Memory game package
 * Shared vector types and the controller state encoding
 */

package memoryGamePkg;

    // One bit per button or LED, button 0 on bit 0
    typedef logic [3:0] buttonT;

    // Sequence address, play counter and round counter
    typedef logic [3:0] indexT;

    // Play window and LED phase timers
    typedef logic [7:0] timerT;

    // Seven-segment pattern, active low, bit 6 is segment g
    typedef logic [6:0] segT;

    // Four bits wide so the state shows directly on a hex display
    typedef enum logic [3:0] {
        IDLE      = 4'h0,
        INIT      = 4'h1,
        SHOWON    = 4'h2,
        SHOWOFF   = 4'h3,
        SHOWNEXT  = 4'h4,
        WAITPLAY  = 4'h5,
        CHECKPLAY = 4'h6,
        NEXTPLAY  = 4'h7,
        NEXTROUND = 4'h8,
        WON       = 4'hA,
        LOST      = 4'hB,
        TIMEDOUT  = 4'hC
    } gameStateT;

endpackage

/* common/gameCtrlIf.sv */
/*
 * Controller to datapath bus
 * Control strobes one way, condition flags the other
 */

`timescale 1ns/1ps

interface gameCtrlIf;

    // Control strobes from the controller
    logic clrPlay;
    logic incPlay;
    logic clrRound;
    logic incRound;
    logic loadLevel;
    logic clrPlayTimer;
    logic runPlayTimer;
    logic clrLedTimer;
    logic runLedTimer;
    logic showLeds;

    // Condition flags from the datapath
    logic pressed;
    logic playCorrect;
    logic playIsRound;
    logic lastRound;
    logic playTimeout;
    logic ledOnDone;
    logic ledOffDone;

    modport ctrl (
        output clrPlay, incPlay, clrRound, incRound, loadLevel,
        output clrPlayTimer, runPlayTimer, clrLedTimer, runLedTimer, showLeds,
        input  pressed, playCorrect, playIsRound, lastRound, playTimeout,
        input  ledOnDone, ledOffDone
    );

    modport data (
        input  clrPlay, incPlay, clrRound, incRound, loadLevel,
        input  clrPlayTimer, runPlayTimer, clrLedTimer, runLedTimer, showLeds,
        output pressed, playCorrect, playIsRound, lastRound, playTimeout,
        output ledOnDone, ledOffDone
    );

endinterface

/* logic/hexToSevenSeg.sv */
/*
 * Hex to seven-segment decoder, active-low outputs
 */

`timescale 1ns/1ps

module hexToSevenSeg (
    input  memoryGamePkg::indexT hexValue,
    output memoryGamePkg::segT   segments
);

    // Segment order gfedcba
    always_comb begin
        case (hexValue)
            4'h0:    segments = 7'b1000000;
            4'h1:    segments = 7'b1111001;
            4'h2:    segments = 7'b0100100;
            4'h3:    segments = 7'b0110000;
            4'h4:    segments = 7'b0011001;
            4'h5:    segments = 7'b0010010;
            4'h6:    segments = 7'b0000010;
            4'h7:    segments = 7'b1111000;
            4'h8:    segments = 7'b0000000;
            4'h9:    segments = 7'b0010000;
            4'hA:    segments = 7'b0001000;
            4'hB:    segments = 7'b0000011;
            4'hC:    segments = 7'b1000110;
            4'hD:    segments = 7'b0100001;
            4'hE:    segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

/* game/gameDatapath.sv */
/*
 * Memory game datapath
 * Sequence ROM, counters, button capture, level registers and timers
 */

`timescale 1ns/1ps
`include "memoryGame_defs.svh"

module gameDatapath (
    input  logic                   clock,
    input  logic                   rstN,
    input  memoryGamePkg::buttonT  buttons,
    input  logic                   roundLevel,
    input  logic                   timeLevel,
    gameCtrlIf.data                bus,
    output memoryGamePkg::buttonT  leds,
    output memoryGamePkg::indexT   dbPlay,
    output memoryGamePkg::indexT   dbRound,
    output memoryGamePkg::buttonT  dbMemory
);

    // Fixed game sequence, one-hot per entry
    localparam memoryGamePkg::buttonT seqRom [`SEQ_DEPTH] = '{
        4'h1, 4'h2, 4'h4, 4'h8, 4'h2, 4'h1, 4'h8, 4'h4,
        4'h4, 4'h8, 4'h1, 4'h2, 4'h8, 4'h2, 4'h4, 4'h1
    };

    memoryGamePkg::indexT  playCount;
    memoryGamePkg::indexT  roundCount;
    memoryGamePkg::indexT  lastIndex;
    memoryGamePkg::buttonT romCode;
    memoryGamePkg::buttonT buttonsPrev;
    memoryGamePkg::buttonT playReg;
    memoryGamePkg::timerT  playTimer;
    memoryGamePkg::timerT  ledTimer;
    memoryGamePkg::timerT  playLimit;
    logic                  roundLevelReg;
    logic                  timeLevelReg;
    logic                  pressEdge;

    // Play and round counters
    always_ff @(posedge clock) begin
        if (!rstN) begin
            playCount  <= '0;
            roundCount <= '0;
        end else begin
            if (bus.clrPlay)
                playCount <= '0;
            else if (bus.incPlay)
                playCount <= playCount + 1'b1;

            if (bus.clrRound)
                roundCount <= '0;
            else if (bus.incRound)
                roundCount <= roundCount + 1'b1;
        end
    end

    // Levels are latched once per game so later toggles are ignored
    always_ff @(posedge clock) begin
        if (!rstN) begin
            roundLevelReg <= 1'b0;
            timeLevelReg  <= 1'b0;
        end else if (bus.loadLevel) begin
            roundLevelReg <= roundLevel;
            timeLevelReg  <= timeLevel;
        end
    end

    // Rising edge from all released to any button down
    assign pressEdge = (buttons != '0) && (buttonsPrev == '0);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            buttonsPrev <= '0;
            bus.pressed <= 1'b0;
        end else begin
            buttonsPrev <= buttons;
            bus.pressed <= pressEdge;
        end
    end

    always_ff @(posedge clock) begin
        if (pressEdge)
            playReg <= buttons;
    end

    // Play window and LED phase timers, clear wins over run
    always_ff @(posedge clock) begin
        if (!rstN) begin
            playTimer <= '0;
            ledTimer  <= '0;
        end else begin
            if (bus.clrPlayTimer)
                playTimer <= '0;
            else if (bus.runPlayTimer)
                playTimer <= playTimer + 1'b1;

            if (bus.clrLedTimer)
                ledTimer <= '0;
            else if (bus.runLedTimer)
                ledTimer <= ledTimer + 1'b1;
        end
    end

    assign romCode   = seqRom[playCount];
    assign lastIndex = roundLevelReg ? memoryGamePkg::indexT'(`HARD_LAST)
                                     : memoryGamePkg::indexT'(`EASY_LAST);
    // Flag on the last cycle of the window
    assign playLimit = timeLevelReg ? memoryGamePkg::timerT'(`PLAY_TIMEOUT_SHORT - 1)
                                    : memoryGamePkg::timerT'(`PLAY_TIMEOUT_LONG - 1);

    assign bus.playCorrect = (playReg == romCode);
    assign bus.playIsRound = (playCount == roundCount);
    assign bus.lastRound   = (roundCount == lastIndex);
    assign bus.playTimeout = (playTimer == playLimit);
    assign bus.ledOnDone   = (ledTimer == memoryGamePkg::timerT'(`LED_ON_CYCLES - 1));
    assign bus.ledOffDone  = (ledTimer == memoryGamePkg::timerT'(`LED_OFF_CYCLES - 1));

    assign leds     = bus.showLeds ? romCode : '0;
    assign dbPlay   = playCount;
    assign dbRound  = roundCount;
    assign dbMemory = romCode;

    // A press pulse always comes with a captured nonzero code
    pressedHasCode: assert property (
        @(posedge clock) disable iff (!rstN)
        bus.pressed |-> (playReg != '0)
    );

endmodule

/* game/gameController.sv */
/*
 * Memory game controller
 * State machine for show phase, player turns and game end
 */

`timescale 1ns/1ps

module gameController (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 start,
    gameCtrlIf.ctrl              bus,
    output logic                 won,
    output logic                 lost,
    output logic                 ready,
    output logic                 timedOut,
    output logic                 playerTurn,
    output memoryGamePkg::indexT dbState
);

    memoryGamePkg::gameStateT state;
    memoryGamePkg::gameStateT nextState;

    always_ff @(posedge clock) begin
        if (!rstN)
            state <= memoryGamePkg::IDLE;
        else
            state <= nextState;
    end

    always_comb begin
        nextState        = state;
        bus.clrPlay      = 1'b0;
        bus.incPlay      = 1'b0;
        bus.clrRound     = 1'b0;
        bus.incRound     = 1'b0;
        bus.loadLevel    = 1'b0;
        bus.clrPlayTimer = 1'b0;
        bus.runPlayTimer = 1'b0;
        bus.clrLedTimer  = 1'b0;
        bus.runLedTimer  = 1'b0;
        bus.showLeds     = 1'b0;

        case (state)
            memoryGamePkg::INIT: begin
                bus.clrPlay      = 1'b1;
                bus.clrRound     = 1'b1;
                bus.loadLevel    = 1'b1;
                bus.clrLedTimer  = 1'b1;
                bus.clrPlayTimer = 1'b1;
                nextState        = memoryGamePkg::SHOWON;
            end
            memoryGamePkg::SHOWON: begin
                bus.showLeds    = 1'b1;
                bus.runLedTimer = 1'b1;
                if (bus.ledOnDone) begin
                    bus.clrLedTimer = 1'b1;
                    nextState       = memoryGamePkg::SHOWOFF;
                end
            end
            memoryGamePkg::SHOWOFF: begin
                bus.runLedTimer = 1'b1;
                if (bus.ledOffDone) begin
                    bus.clrLedTimer = 1'b1;
                    nextState       = memoryGamePkg::SHOWNEXT;
                end
            end
            memoryGamePkg::SHOWNEXT: begin
                // Whole round shown, hand over to the player from entry 0
                if (bus.playIsRound) begin
                    bus.clrPlay      = 1'b1;
                    bus.clrPlayTimer = 1'b1;
                    nextState        = memoryGamePkg::WAITPLAY;
                end else begin
                    bus.incPlay = 1'b1;
                    nextState   = memoryGamePkg::SHOWON;
                end
            end
            memoryGamePkg::WAITPLAY: begin
                bus.runPlayTimer = 1'b1;
                if (bus.pressed)
                    nextState = memoryGamePkg::CHECKPLAY;
                else if (bus.playTimeout)
                    nextState = memoryGamePkg::TIMEDOUT;
            end
            memoryGamePkg::CHECKPLAY: begin
                if (!bus.playCorrect)
                    nextState = memoryGamePkg::LOST;
                else if (!bus.playIsRound)
                    nextState = memoryGamePkg::NEXTPLAY;
                else if (bus.lastRound)
                    nextState = memoryGamePkg::WON;
                else
                    nextState = memoryGamePkg::NEXTROUND;
            end
            memoryGamePkg::NEXTPLAY: begin
                bus.incPlay      = 1'b1;
                bus.clrPlayTimer = 1'b1;
                nextState        = memoryGamePkg::WAITPLAY;
            end
            memoryGamePkg::NEXTROUND: begin
                bus.incRound    = 1'b1;
                bus.clrPlay     = 1'b1;
                bus.clrLedTimer = 1'b1;
                nextState       = memoryGamePkg::SHOWON;
            end
            // IDLE and the end states wait for start
            default: begin
                if (start)
                    nextState = memoryGamePkg::INIT;
            end
        endcase
    end

    assign won        = (state == memoryGamePkg::WON);
    assign timedOut   = (state == memoryGamePkg::TIMEDOUT);
    assign lost       = (state == memoryGamePkg::LOST) || timedOut;
    assign ready      = won || lost;
    assign playerTurn = (state == memoryGamePkg::WAITPLAY);
    assign dbState    = memoryGamePkg::indexT'(state);

    wonLostExclusive: assert property (
        @(posedge clock) disable iff (!rstN)
        !(won && lost)
    );

    // LEDs only lit during the on phase of the show
    showOnlyInShowOn: assert property (
        @(posedge clock) disable iff (!rstN)
        bus.showLeds |-> (state == memoryGamePkg::SHOWON)
    );

endmodule

/* logic/memoryGameTop.sv */
/*
 * Memory game top level
 * Controller, datapath and four debug displays
 */

`timescale 1ns/1ps

module memoryGameTop (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic                  start,
    input  memoryGamePkg::buttonT buttons,
    input  logic                  roundLevel,
    input  logic                  timeLevel,
    output logic                  won,
    output logic                  lost,
    output logic                  ready,
    output logic                  timedOut,
    output logic                  playerTurn,
    output memoryGamePkg::buttonT leds,
    output logic                  dbCorrect,
    output memoryGamePkg::segT    dbPlaySeg,
    output memoryGamePkg::segT    dbRoundSeg,
    output memoryGamePkg::segT    dbMemorySeg,
    output memoryGamePkg::segT    dbStateSeg
);

    gameCtrlIf ctrlBus ();

    memoryGamePkg::indexT  dbPlay;
    memoryGamePkg::indexT  dbRound;
    memoryGamePkg::buttonT dbMemory;
    memoryGamePkg::indexT  dbState;

    assign dbCorrect = ctrlBus.playCorrect;

    gameDatapath dataPath0 (
        .clock      ( clock         ),
        .rstN       ( rstN          ),
        .buttons    ( buttons       ),
        .roundLevel ( roundLevel    ),
        .timeLevel  ( timeLevel     ),
        .bus        ( ctrlBus.data  ),
        .leds       ( leds          ),
        .dbPlay     ( dbPlay        ),
        .dbRound    ( dbRound       ),
        .dbMemory   ( dbMemory      )
    );

    gameController controller0 (
        .clock      ( clock         ),
        .rstN       ( rstN          ),
        .start      ( start         ),
        .bus        ( ctrlBus.ctrl  ),
        .won        ( won           ),
        .lost       ( lost          ),
        .ready      ( ready         ),
        .timedOut   ( timedOut      ),
        .playerTurn ( playerTurn    ),
        .dbState    ( dbState       )
    );

    // Debug displays
    hexToSevenSeg playDisplay (
        .hexValue ( dbPlay      ),
        .segments ( dbPlaySeg   )
    );

    hexToSevenSeg roundDisplay (
        .hexValue ( dbRound     ),
        .segments ( dbRoundSeg  )
    );

    hexToSevenSeg memoryDisplay (
        .hexValue ( dbMemory    ),
        .segments ( dbMemorySeg )
    );

    hexToSevenSeg stateDisplay (
        .hexValue ( dbState     ),
        .segments ( dbStateSeg  )
    );

endmodule

/* bench/clockGen.sv */
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for 4 cycles
 */

`timescale 1ns/1ps

module clockGen (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rstN = 1'b1;
    end

endmodule

/* bench/memoryGameTb.sv */
/*
 * Memory game testbench
 * Replays scenarios from a data file with a simple player model
 */

`timescale 1ns/1ps
`include "memoryGame_defs.svh"

module memoryGameTb;

    logic                  clock;
    logic                  rstN;
    logic                  start;
    logic                  roundLevel;
    logic                  timeLevel;
    memoryGamePkg::buttonT buttons;
    memoryGamePkg::buttonT leds;
    logic                  won;
    logic                  lost;
    logic                  ready;
    logic                  timedOut;
    logic                  playerTurn;
    logic                  dbCorrect;
    memoryGamePkg::segT    dbPlaySeg;
    memoryGamePkg::segT    dbRoundSeg;
    memoryGamePkg::segT    dbMemorySeg;
    memoryGamePkg::segT    dbStateSeg;

    // Sequence in words 0 to 15, then five words per scenario
    logic [7:0]            stimData [64];
    memoryGamePkg::buttonT seqCodes [`SEQ_DEPTH];
    integer                seed = 57907;
    int                    errorCount = 0;
    int                    checkCount = 0;
    int                    cycleCount = 0;
    int                    cycleLimit = 0;
    int                    scenarioCount = 0;

    clockGen clockGen0 (
        .clock ( clock ),
        .rstN  ( rstN  )
    );

    memoryGameTop dut0 (
        .clock       ( clock       ),
        .rstN        ( rstN        ),
        .start       ( start       ),
        .buttons     ( buttons     ),
        .roundLevel  ( roundLevel  ),
        .timeLevel   ( timeLevel   ),
        .won         ( won         ),
        .lost        ( lost        ),
        .ready       ( ready       ),
        .timedOut    ( timedOut    ),
        .playerTurn  ( playerTurn  ),
        .leds        ( leds        ),
        .dbCorrect   ( dbCorrect   ),
        .dbPlaySeg   ( dbPlaySeg   ),
        .dbRoundSeg  ( dbRoundSeg  ),
        .dbMemorySeg ( dbMemorySeg ),
        .dbStateSeg  ( dbStateSeg  )
    );

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, actual,
                     expected);
            errorCount++;
        end
    endtask

    // Common-cathode digit patterns, inverted for the active-low displays
    function automatic memoryGamePkg::segT hexSegments(input logic [3:0] value);
        logic [6:0] lit;
        case (value)
            4'h0:    lit = 7'h3F;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5B;
            4'h3:    lit = 7'h4F;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6D;
            4'h6:    lit = 7'h7D;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7F;
            4'h9:    lit = 7'h6F;
            4'hA:    lit = 7'h77;
            4'hB:    lit = 7'h7C;
            4'hC:    lit = 7'h39;
            4'hD:    lit = 7'h5E;
            4'hE:    lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // Debug displays while the player is expected to press entry p of round r
    task automatic checkDebug(input int r, input int p);
        checkValue("dbStateSeg", dbStateSeg, hexSegments(memoryGamePkg::WAITPLAY));
        checkValue("dbPlaySeg", dbPlaySeg, hexSegments(p[3:0]));
        checkValue("dbRoundSeg", dbRoundSeg, hexSegments(r[3:0]));
        checkValue("dbMemorySeg", dbMemorySeg, hexSegments(seqCodes[p]));
    endtask

    // Returns on the falling edge where the player may press, or at game end
    task automatic waitTurn();
        while (!playerTurn && !ready)
            @(negedge clock);
    endtask

    // Random idle gap, then hold the code for 3 cycles and release
    task automatic pressButton(input memoryGamePkg::buttonT code);
        int gap;
        gap = $unsigned($random(seed)) % 8;
        repeat (gap) @(negedge clock);
        buttons = code;
        repeat (3) @(negedge clock);
        buttons = '0;
    endtask

    // Each lit phase must carry the next sequence entry
    task automatic watchShow(input int r, output bit aborted);
        memoryGamePkg::buttonT prevLeds;
        int shown;
        prevLeds = '0;
        shown = 0;
        aborted = 1'b0;
        while (!playerTurn && !ready) begin
            @(negedge clock);
            if (leds != '0 && prevLeds == '0) begin
                if (shown <= r)
                    checkValue("leds", leds, seqCodes[shown]);
                shown++;
            end
            prevLeds = leds;
        end
        if (ready && !playerTurn) begin
            $display("ERROR at %0t: game ended before round %0d was played", $time, r);
            errorCount++;
            aborted = 1'b1;
        end else begin
            checkValue("shownEntries", shown, r + 1);
        end
    endtask

    task automatic runScenario(input int base);
        int ending;
        int goodRounds;
        int playIdx;
        int finalRound;
        int lastPlay;
        int waited;
        bit aborted;
        logic windowOk;
        memoryGamePkg::buttonT code;
        roundLevel = stimData[base][0];
        timeLevel  = stimData[base + 1][0];
        ending     = stimData[base + 2];
        goodRounds = stimData[base + 3];
        playIdx    = stimData[base + 4];
        $display("Scenario: roundLevel %0d timeLevel %0d ending %0d rounds %0d play %0d",
                 roundLevel, timeLevel, ending, goodRounds, playIdx);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        // Now in INIT, the previous result must be gone
        checkValue("won", won, 1'b0);
        checkValue("lost", lost, 1'b0);
        checkValue("timedOut", timedOut, 1'b0);
        checkValue("ready", ready, 1'b0);

        finalRound = (ending == 0) ? goodRounds - 1 : goodRounds;
        for (int r = 0; r <= finalRound; r++) begin
            watchShow(r, aborted);
            if (aborted)
                return;
            // Levels were latched at start, a later change must not matter
            if (r == 1)
                roundLevel = ~stimData[base][0];
            lastPlay = (ending != 0 && r == goodRounds) ? playIdx - 1 : r;
            for (int p = 0; p <= lastPlay; p++) begin
                waitTurn();
                if (ready) begin
                    $display("ERROR at %0t: game ended early in round %0d at play %0d",
                             $time, r, p);
                    errorCount++;
                    return;
                end
                checkDebug(r, p);
                pressButton(seqCodes[p]);
                // Play counter has not moved on yet
                checkValue("dbCorrect", dbCorrect, 1'b1);
            end
        end

        if (ending == 1) begin
            waitTurn();
            checkDebug(goodRounds, playIdx);
            code = seqCodes[playIdx];
            pressButton({code[2:0], code[3]});
            checkValue("dbCorrect", dbCorrect, 1'b0);
        end else if (ending == 2) begin
            waitTurn();
            waited = 0;
            while (!ready) begin
                @(negedge clock);
                waited++;
            end
            if (timeLevel)
                windowOk = (waited < `PLAY_TIMEOUT_SHORT + 2);
            else
                windowOk = (waited >= `PLAY_TIMEOUT_LONG);
            checkValue("timeoutWindowOk", windowOk, 1'b1);
        end

        while (!ready)
            @(negedge clock);
        // Result must hold until the next start
        repeat (3) @(negedge clock);
        checkValue("won", won, ending == 0);
        checkValue("lost", lost, ending != 0);
        checkValue("timedOut", timedOut, ending == 2);
        checkValue("ready", ready, 1'b1);
    endtask

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Run hung: no result after %0d cycles", cycleCount);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : mainFlow
        int base;
        int roundsReached;
        int budget;
        start      = 1'b0;
        buttons    = '0;
        roundLevel = 1'b0;
        timeLevel  = 1'b0;
        $readmemh("bench/gameInput.txt", stimData);
        for (int i = 0; i < `SEQ_DEPTH; i++)
            seqCodes[i] = stimData[i][3:0];

        // Worst case per round is every entry shown plus a full long window
        budget = 0;
        base = `SEQ_DEPTH;
        while (base + 4 < 64 && stimData[base] !== 8'hFF && !$isunknown(stimData[base])) begin
            roundsReached = stimData[base + 3] + ((stimData[base + 2] != 0) ? 1 : 0);
            budget += roundsReached * roundsReached *
                      (`LED_ON_CYCLES + `LED_OFF_CYCLES + `PLAY_TIMEOUT_LONG);
            base += 5;
            scenarioCount++;
        end
        cycleLimit = budget * 3 / 2;
        if (scenarioCount == 0) begin
            $display("ERROR: no scenarios found in bench/gameInput.txt");
            errorCount++;
        end

        wait (rstN === 1'b1);
        @(negedge clock);
        checkValue("won", won, 1'b0);
        checkValue("lost", lost, 1'b0);
        checkValue("timedOut", timedOut, 1'b0);
        checkValue("ready", ready, 1'b0);
        checkValue("playerTurn", playerTurn, 1'b0);
        checkValue("leds", leds, 4'h0);

        for (int s = 0; s < scenarioCount; s++)
            runScenario(`SEQ_DEPTH + 5 * s);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* bench/gameInput.txt */
// First data line: sequence entries 0 to 15, one-hot button codes in hex
// Then one scenario per line: roundLevel timeLevel ending rounds play, all hex
// ending 0 plays every round, 1 presses a wrong code, 2 presses nothing
// rounds are played correctly first, play is the press in the next round
// where the ending happens; FF closes the list
1 2 4 8 2 1 8 4 4 8 1 2 8 2 4 1
// Easy level, all 4 rounds
0 0 0 04 00
// Hard level, all 16 rounds
1 0 0 10 00
// Wrong press in round 2 at play 1
0 0 1 02 01
// Wrong press at the very first play
1 1 1 00 00
// No press, short window, round 1 at play 1
0 1 2 01 01
// No press, long window, round 0
0 0 2 00 00
// Wrong press deep in a hard game
1 0 1 05 03
FF

/* filelist.f */
+incdir+common
common/memoryGamePkg.sv
common/gameCtrlIf.sv
logic/hexToSevenSeg.sv
game/gameDatapath.sv
game/gameController.sv
logic/memoryGameTop.sv
bench/clockGen.sv
bench/memoryGameTb.sv
